/* src.f */
isa_pkg.sv
alu_pkg.sv
reg_file.sv
alu.sv
decode.sv
execute.sv
result.sv
core_top.sv
tb_core.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_core -f src.f -o tb_core_sim
./obj_dir/tb_core_sim > sim.log
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
echo "simulation passed"

/* tb_core.sv */
module tb_core;
  timeunit 1ns;
  timeprecision 1ps;
  import isa_pkg::*;

  localparam int MUL_LAT = 4;
  localparam int TIMEOUT = 2000;  // ~4x program length with stalls

  logic        clk_i, rst_i, ir_valid_i;
  logic [63:0] ir_i;
  logic [31:0] pc_i, pc_o, wb_data_o, retired_o;
  logic        stall_o, pc_set_o, halt_o, wb_en_o;
  logic [2:0]  ccr_o;
  logic [3:0]  wb_reg_o;

  logic [31:0] mregs [16];
  logic        m_eq = 1'b0, m_lt = 1'b0, m_ltu = 1'b0, halted = 1'b0;
  int          skip = 0, writes = 0, exp_stall = 0, stall_seen = 0, cycles = 0;
  int          val_errs = 0, other_errs = 0;
  logic [35:0] exp_wb [$];
  logic [31:0] exp_pc [$];
  logic [35:0] wb_item;
  logic [31:0] pc_item;
  logic [31:0] next_pc = 32'h100;
  integer      seed = 32'ha98d;

  core_top #(.MUL_LATENCY(MUL_LAT)) core_top_i (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i)
  begin
    cycles++;
    if (cycles >= TIMEOUT)
    begin
      $display("timeout: run still busy after %0d cycles", TIMEOUT);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  function automatic logic [63:0] enc_r(input logic [3:0] t, op, ra, rb, rc);
    return {32'h0, t, op, ra, rb, rc, 11'h0, 1'b0};
  endfunction

  function automatic logic [63:0] enc_i(input logic [3:0] t, op, ra, rb,
                                        input logic [14:0] sv, input logic sz,
                                        input logic [31:0] ext);
    return {ext, t, op, ra, rb, sv, sz};
  endfunction

  function automatic logic [31:0] alu_ref(input logic [2:0] f, input logic [31:0] a, b);
    case (f)
      3'd0: return a + b;
      3'd1: return a - b;
      3'd2: return a & b;
      3'd3: return a | b;
      3'd4: return a ^ b;
      3'd5: return a << b[4:0];
      3'd6: return a >> b[4:0];
      default: return (a >> b[4:0]) | (~(32'hffffffff >> b[4:0]) & {32{a[31]}});
    endcase
  endfunction

  function automatic logic cond_ref(input logic [3:0] c);
    case (c)
      BR_BRA:  return 1'b1;
      BR_BEQ:  return m_eq;
      BR_BNE:  return !m_eq;
      BR_BGTU: return !m_ltu && !m_eq;
      BR_BGT:  return !m_lt && !m_eq;
      BR_BGE:  return !m_lt;
      BR_BLE:  return m_lt || m_eq;
      BR_BLT:  return m_lt;
      BR_BGEU: return !m_ltu;
      BR_BLTU: return m_ltu;
      BR_BLEU: return m_ltu || m_eq;
      default: return 1'b0;
    endcase
  endfunction

  // applies one accepted instruction to the model state
  function automatic void model_step(input logic [63:0] instr, input logic [31:0] pc);
    instr_word_t w;
    logic [31:0] a, b, sx, res, target;
    logic        wr, jump;
    w      = instr[31:0];
    a      = mregs[w.r.rb];
    b      = mregs[w.r.rc];
    sx     = {{17{w.i.sval[14]}}, w.i.sval};
    res    = 32'h0;
    target = 32'h0;
    wr     = 1'b0;
    jump   = 1'b0;
    if (halted)
      return;
    if (skip > 0)
    begin
      skip--;  // annulled behind a taken branch
      return;
    end
    case (w.r.itype)
      T_ALU:
      begin
        res = alu_ref(w.r.op[2:0], a, w.r.op[3] ? sx : b);
        wr  = 1'b1;
      end
      T_INT:
        if (w.r.op == OP_MUL)
        begin
          res = a * b;
          wr  = 1'b1;
          exp_stall += MUL_LAT;
        end
      T_LDI:
      begin
        res = w.i.size ? instr[63:32] : {17'h0, w.i.sval};
        wr  = 1'b1;
      end
      T_MOV:
      begin
        res = a;
        wr  = 1'b1;
      end
      T_CMP:
      begin
        m_eq  = (a == b);
        m_lt  = ($signed(a) < $signed(b));
        m_ltu = (a < b);
      end
      T_INH:
        if (w.r.op == OP_HALT)
          halted = 1'b1;
      T_BRANCH:
      begin
        jump   = cond_ref(w.r.op);
        target = pc + (sx << 2);
      end
      T_JUMP:
      begin
        jump   = 1'b1;
        target = w.i.size ? instr[63:32] : a + sx;
      end
      default: ;
    endcase
    if (wr)
    begin
      mregs[w.r.ra] = res;
      exp_wb.push_back({w.r.ra, res});
      writes++;
    end
    if (jump)
    begin
      exp_pc.push_back(target);
      skip = 2;
    end
  endfunction

  // present one instruction, hold it until accepted
  task automatic issue(input logic [63:0] instr);
    logic accepted;
    ir_i       = instr;
    pc_i       = next_pc;
    ir_valid_i = 1'b1;
    do
    begin
      @(negedge clk_i);
      accepted = !stall_o;
      if (stall_o)
        stall_seen++;
      @(posedge clk_i);
      #1;
    end while (!accepted);
    model_step(instr, pc_i);
    next_pc += 8;
  endtask

  task automatic check_reset();
    @(negedge clk_i);
    if (stall_o !== 1'b0)
    begin
      $display("FAILED stall_o: got %h, expected %h", stall_o, 1'b0);
      val_errs++;
    end
    if (pc_set_o !== 1'b0)
    begin
      $display("FAILED pc_set_o: got %h, expected %h", pc_set_o, 1'b0);
      val_errs++;
    end
    if (halt_o !== 1'b0)
    begin
      $display("FAILED halt_o: got %h, expected %h", halt_o, 1'b0);
      val_errs++;
    end
    if (wb_en_o !== 1'b0)
    begin
      $display("FAILED wb_en_o: got %h, expected %h", wb_en_o, 1'b0);
      val_errs++;
    end
    if (retired_o !== 32'h0)
    begin
      $display("FAILED retired_o: got %h, expected %h", retired_o, 32'h0);
      val_errs++;
    end
    if (ccr_o !== 3'h0)
    begin
      $display("FAILED ccr_o: got %h, expected %h", ccr_o, 3'h0);
      val_errs++;
    end
    @(posedge clk_i);
    #1;
  endtask

  task automatic alu_section();
    issue(enc_i(T_LDI, 4'h0, 4'd1, 4'd0, 15'h1234, 1'b0, 32'h0));
    issue(enc_i(T_LDI, 4'h0, 4'd2, 4'd0, 15'h0, 1'b1, 32'hdeadbeef));
    issue(enc_i(T_LDI, 4'h0, 4'd3, 4'd0, 15'h7fff, 1'b0, 32'h0));
    issue(enc_i(T_LDI, 4'h0, 4'd4, 4'd0, 15'h0, 1'b1, 32'h80000005));
    for (int f = 0; f < 8; f++)
    begin
      issue(enc_r(T_ALU, 4'(f), 4'(5 + f), 4'd2, 4'd4));
      issue(enc_i(T_ALU, 4'(8 + f), 4'd13, 4'd4, 15'h7ffd, 1'b0, 32'h0));  // imm -3
    end
    issue(enc_r(T_MOV, 4'h0, 4'd14, 4'd13, 4'h0));
    for (int k = 0; k < 4; k++)
      issue(enc_i(T_ALU, 4'h8, 4'd15, 4'd15, 15'(k + 1), 1'b0, 32'h0));  // chained
    issue(enc_r(T_ALU, 4'h0, 4'd6, 4'd15, 4'd15));
    issue(enc_r(T_ALU, 4'h1, 4'd7, 4'd6, 4'd14));
  endtask

  task automatic branch_section();
    logic [31:0] pairs [8];
    pairs = '{32'd5, 32'd5, 32'd3, 32'd9, 32'd9, 32'd3, 32'hffffffff, 32'd1};
    for (int p = 0; p < 4; p++)
      for (int c = 0; c <= 10; c++)
      begin
        issue(enc_i(T_LDI, 4'h0, 4'd8, 4'd0, 15'h0, 1'b1, pairs[2 * p]));
        issue(enc_i(T_LDI, 4'h0, 4'd9, 4'd0, 15'h0, 1'b1, pairs[2 * p + 1]));
        issue(enc_r(T_CMP, 4'h0, 4'd0, 4'd8, 4'd9));
        issue(enc_i(T_BRANCH, 4'(c), 4'd0, 4'd0, 15'(c - 5), 1'b0, 32'h0));
        issue(enc_i(T_LDI, 4'h0, 4'd10, 4'd0, 15'(100 + c), 1'b0, 32'h0));
        issue(enc_i(T_LDI, 4'h0, 4'd11, 4'd0, 15'(200 + c), 1'b0, 32'h0));
      end
    issue(enc_i(T_JUMP, 4'h0, 4'd0, 4'd0, 15'h0, 1'b1, 32'h00001000));
    issue(enc_i(T_LDI, 4'h0, 4'd10, 4'd0, 15'd300, 1'b0, 32'h0));
    issue(enc_i(T_LDI, 4'h0, 4'd11, 4'd0, 15'd301, 1'b0, 32'h0));
    issue(enc_i(T_JUMP, 4'h0, 4'd0, 4'd1, 15'h7ff8, 1'b0, 32'h0));  // r1 - 8
    issue(enc_i(T_LDI, 4'h0, 4'd10, 4'd0, 15'd302, 1'b0, 32'h0));
    issue(enc_i(T_LDI, 4'h0, 4'd11, 4'd0, 15'd303, 1'b0, 32'h0));
    issue(enc_i(T_LDI, 4'h0, 4'd10, 4'd0, 15'd304, 1'b0, 32'h0));
  endtask

  task automatic mul_section();
    issue(enc_i(T_LDI, 4'h0, 4'd12, 4'd0, 15'd7, 1'b0, 32'h0));
    issue(enc_r(T_INT, OP_MUL, 4'd13, 4'd12, 4'd2));
    issue(enc_r(T_ALU, 4'h0, 4'd14, 4'd13, 4'd1));  // needs the product
    issue(enc_r(T_INT, OP_MUL, 4'd13, 4'd13, 4'd13));
    issue(enc_r(T_INT, OP_MUL, 4'd5, 4'd13, 4'd12));
    issue(enc_r(T_MOV, 4'h0, 4'd6, 4'd5, 4'h0));
  endtask

  task automatic random_section();
    logic [31:0] r, x;
    for (int n = 0; n < 40; n++)
    begin
      r = $random(seed);
      x = $random(seed);
      case (r[1:0])
        2'd2: issue(enc_i(T_LDI, 4'h0, r[11:8], 4'h0, r[30:16], r[6], x));
        2'd3: issue(enc_r(T_INT, OP_MUL, r[11:8], r[15:12], r[19:16]));
        default:
          if (r[5])
            issue(enc_i(T_ALU, {1'b1, r[4:2]}, r[11:8], r[15:12], r[30:16], 1'b0, 32'h0));
          else
            issue(enc_r(T_ALU, {1'b0, r[4:2]}, r[11:8], r[15:12], r[19:16]));
      endcase
    end
  endtask

  // compare DUT reports against the expected queues
  always @(negedge clk_i)
  begin
    if (!rst_i && wb_en_o === 1'b1)
    begin
      if (exp_wb.size() == 0)
      begin
        $display("writeback to r%0d with no write expected", wb_reg_o);
        other_errs++;
      end
      else
      begin
        wb_item = exp_wb.pop_front();
        if (wb_reg_o !== wb_item[35:32])
        begin
          $display("FAILED wb_reg_o: got %h, expected %h", wb_reg_o, wb_item[35:32]);
          val_errs++;
        end
        if (wb_data_o !== wb_item[31:0])
        begin
          $display("FAILED wb_data_o: got %h, expected %h", wb_data_o, wb_item[31:0]);
          val_errs++;
        end
      end
    end
    if (!rst_i && pc_set_o === 1'b1)
    begin
      if (exp_pc.size() == 0)
      begin
        $display("pc_set_o pulsed with no taken branch expected");
        other_errs++;
      end
      else
      begin
        pc_item = exp_pc.pop_front();
        if (pc_o !== pc_item)
        begin
          $display("FAILED pc_o: got %h, expected %h", pc_o, pc_item);
          val_errs++;
        end
      end
    end
  end

  initial
  begin
    rst_i      = 1'b1;
    ir_i       = 64'h0;
    pc_i       = 32'h0;
    ir_valid_i = 1'b0;
    for (int i = 0; i < 16; i++)
      mregs[i] = 32'h0;
    repeat (5) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    check_reset();
    alu_section();
    branch_section();
    mul_section();
    random_section();
    issue(enc_r(T_INH, OP_HALT, 4'h0, 4'h0, 4'h0));
    issue(enc_i(T_LDI, 4'h0, 4'd1, 4'd0, 15'd55, 1'b0, 32'h0));  // all dead after halt
    issue(enc_r(T_INT, OP_MUL, 4'd2, 4'd2, 4'd2));
    issue(enc_i(T_JUMP, 4'h0, 4'd0, 4'd0, 15'h0, 1'b1, 32'h00002000));
    issue(enc_r(T_MOV, 4'h0, 4'd3, 4'd1, 4'h0));
    ir_valid_i = 1'b0;
    while (exp_wb.size() != 0 || exp_pc.size() != 0)
      @(posedge clk_i);
    repeat (8) @(posedge clk_i);  // room for stray writebacks
    @(negedge clk_i);
    if (halt_o !== 1'b1)
    begin
      $display("FAILED halt_o: got %h, expected %h", halt_o, 1'b1);
      val_errs++;
    end
    if (retired_o !== 32'(writes))
    begin
      $display("FAILED retired_o: got %h, expected %h", retired_o, 32'(writes));
      val_errs++;
    end
    if (stall_seen != exp_stall)
    begin
      $display("stall_o high for %0d cycles, expected %0d", stall_seen, exp_stall);
      other_errs++;
    end
    $display("errors: %0d value mismatches, %0d other failures", val_errs, other_errs);
    if (val_errs + other_errs == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

/* core_top.sv */
module core_top #(
  parameter int MUL_LATENCY = 4
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic [isa_pkg::IR_W-1:0]  ir_i,
  input  logic [31:0]               pc_i,
  input  logic                      ir_valid_i,
  output logic                      stall_o,
  output logic [31:0]               pc_o,
  output logic                      pc_set_o,
  output logic [alu_pkg::CCR_W-1:0] ccr_o,
  output logic                      halt_o,
  output logic                      wb_en_o,
  output logic [3:0]                wb_reg_o,
  output logic [31:0]               wb_data_o,
  output logic [31:0]               retired_o
);
  import isa_pkg::*;

  logic [IR_W-1:0]  d_ir;
  logic [31:0]      d_pc, d_rdata1, d_rdata2;
  logic             d_valid, e_stall, e_wen, w_en;
  logic [31:0]      e_result, w_data, ra_data, rb_data;
  logic [3:0]       e_dest, w_addr, ra_addr, rb_addr;

  assign stall_o = e_stall;

  reg_file reg_file_i (
    .clk_i, .rst_i,
    .ra_addr_i (ra_addr), .rb_addr_i (rb_addr),
    .ra_data_o (ra_data), .rb_data_o (rb_data),
    .w_en_i    (w_en),    .w_addr_i  (w_addr), .w_data_i (w_data)
  );

  decode decode_i (
    .clk_i, .rst_i, .ir_i, .pc_i, .ir_valid_i,
    .stall_i    (e_stall),  .flush_i    (pc_set_o),  // taken branch flushes
    .ex_wen_i   (e_wen),    .ex_dest_i  (e_dest),   .ex_result_i (e_result),
    .wb_en_i    (w_en),     .wb_reg_i   (w_addr),   .wb_data_i   (w_data),
    .ra_addr_o  (ra_addr),  .rb_addr_o  (rb_addr),
    .ra_data_i  (ra_data),  .rb_data_i  (rb_data),
    .d_ir_o     (d_ir),     .d_pc_o     (d_pc),     .d_valid_o   (d_valid),
    .d_rdata1_o (d_rdata1), .d_rdata2_o (d_rdata2)
  );

  execute #(.MUL_LATENCY(MUL_LATENCY)) execute_i (
    .clk_i, .rst_i,
    .d_ir_i     (d_ir),     .d_pc_i     (d_pc),     .d_valid_i (d_valid),
    .d_rdata1_i (d_rdata1), .d_rdata2_i (d_rdata2), .stall_o   (e_stall),
    .e_result_o (e_result), .e_dest_o   (e_dest),   .e_wen_o   (e_wen),
    .pc_o, .pc_set_o, .ccr_o, .halt_o
  );

  result result_i (
    .clk_i, .rst_i,
    .e_wen_i (e_wen), .e_dest_i (e_dest), .e_result_i (e_result),
    .w_en_o  (w_en),  .w_addr_o (w_addr), .w_data_o   (w_data),
    .wb_en_o, .wb_reg_o, .wb_data_o, .retired_o
  );

endmodule

/* result.sv */
module result (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        e_wen_i,
  input  logic [3:0]  e_dest_i,
  input  logic [31:0] e_result_i,
  output logic        w_en_o,
  output logic [3:0]  w_addr_o,
  output logic [31:0] w_data_o,
  output logic        wb_en_o,
  output logic [3:0]  wb_reg_o,
  output logic [31:0] wb_data_o,
  output logic [31:0] retired_o
);

  logic        wen_q;
  logic [3:0]  reg_q;
  logic [31:0] data_q;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      wen_q     <= 1'b0;
      retired_o <= 32'h0;
    end
    else
    begin
      wen_q     <= e_wen_i;
      retired_o <= retired_o + {31'h0, e_wen_i};  // moves with wb_en_o
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (e_wen_i)
    begin
      reg_q  <= e_dest_i;
      data_q <= e_result_i;
    end
  end

  // same registers feed the reg file, forwarding and the report
  assign w_en_o    = wen_q;
  assign w_addr_o  = reg_q;
  assign w_data_o  = data_q;
  assign wb_en_o   = wen_q;
  assign wb_reg_o  = reg_q;
  assign wb_data_o = data_q;

endmodule

/* execute.sv */
module execute #(
  parameter int MUL_LATENCY = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic [isa_pkg::IR_W-1:0]   d_ir_i,
  input  logic [31:0]                d_pc_i,
  input  logic                       d_valid_i,
  input  logic [31:0]                d_rdata1_i,
  input  logic [31:0]                d_rdata2_i,
  output logic                       stall_o,
  output logic [31:0]                e_result_o,
  output logic [3:0]                 e_dest_o,
  output logic                       e_wen_o,
  output logic [31:0]                pc_o,
  output logic                       pc_set_o,
  output logic [alu_pkg::CCR_W-1:0]  ccr_o,
  output logic                       halt_o
);
  import isa_pkg::*;
  import alu_pkg::*;

  localparam int DW = $clog2(MUL_LATENCY + 1);

  instr_word_t      ir;
  logic [31:0]      ext_val, sval, uval;
  logic [DW-1:0]    delay, delay_next;
  logic             live, is_mul, stall_start, go, taken;
  alu_func_t        alu_func;
  logic [31:0]      alu_in1, alu_in2, alu_out, product;
  logic             alu_c, alu_n, alu_v, alu_z;
  logic [31:0]      result_next, pc_next;
  logic             wen_next, pc_set_next, halt_next;
  logic [CCR_W-1:0] ccr_next;

  assign ir      = d_ir_i[31:0];
  assign ext_val = d_ir_i[IR_W-1:32];
  assign sval    = {{17{ir.i.sval[14]}}, ir.i.sval};
  assign uval    = {17'h0, ir.i.sval};

  assign live        = d_valid_i && !halt_o;  // bubbles after halt
  assign is_mul      = (ir.r.itype == T_INT) && (ir.r.op == OP_MUL);
  assign stall_start = live && is_mul && (delay == '0);
  assign stall_o     = stall_start || (delay > 1);
  assign go          = live && !stall_o;
  assign product     = d_rdata1_i * d_rdata2_i;  // low word only

  always_comb
  begin
    delay_next = delay;
    if (delay != '0)
      delay_next = delay - 1'b1;
    if (stall_start)
      delay_next = DW'(MUL_LATENCY);
  end

  always_comb
  begin
    alu_in1  = d_rdata1_i;
    alu_in2  = d_rdata2_i;
    alu_func = alu_func_t'(ir.r.op[2:0]);
    case (ir.r.itype)
      T_ALU:
        if (ir.r.op[3])
          alu_in2 = sval;  // immediate form
      T_CMP: alu_func = ALU_SUB;
      T_BRANCH:
      begin
        alu_func = ALU_ADD;
        alu_in1  = {sval[29:0], 2'b00};
        alu_in2  = d_pc_i;
      end
      T_JUMP:
      begin
        alu_func = ALU_ADD;
        alu_in2  = sval;
      end
      default: ;
    endcase
  end

  always_comb
  begin
    case (ir.r.op)
      BR_BRA:  taken = 1'b1;
      BR_BEQ:  taken = ccr_o[CCR_EQ];
      BR_BNE:  taken = ~ccr_o[CCR_EQ];
      BR_BGTU: taken = ~(ccr_o[CCR_LTU] | ccr_o[CCR_EQ]);
      BR_BGT:  taken = ~(ccr_o[CCR_LT] | ccr_o[CCR_EQ]);
      BR_BGE:  taken = ~ccr_o[CCR_LT];
      BR_BLE:  taken = ccr_o[CCR_LT] | ccr_o[CCR_EQ];
      BR_BLT:  taken = ccr_o[CCR_LT];
      BR_BGEU: taken = ~ccr_o[CCR_LTU];
      BR_BLTU: taken = ccr_o[CCR_LTU];
      BR_BLEU: taken = ccr_o[CCR_LTU] | ccr_o[CCR_EQ];
      default: taken = 1'b0;
    endcase
  end

  always_comb
  begin
    result_next = alu_out;
    wen_next    = 1'b0;
    ccr_next    = ccr_o;
    halt_next   = halt_o;
    pc_next     = pc_o;
    pc_set_next = 1'b0;  // one cycle pulse
    if (go)
    begin
      case (ir.r.itype)
        T_ALU: wen_next = 1'b1;
        T_INT:
          if (is_mul)
          begin
            result_next = product;  // counter has run out
            wen_next    = 1'b1;
          end
        T_LDI:
        begin
          result_next = ir.r.size ? ext_val : uval;
          wen_next    = 1'b1;
        end
        T_MOV:
        begin
          result_next = d_rdata1_i;
          wen_next    = 1'b1;
        end
        T_CMP:
        begin
          ccr_next[CCR_LTU] = alu_c;
          ccr_next[CCR_LT]  = alu_n ^ alu_v;
          ccr_next[CCR_EQ]  = alu_z;
        end
        T_INH:
          if (ir.r.op == OP_HALT)
            halt_next = 1'b1;
        T_BRANCH:
        begin
          pc_next     = alu_out;
          pc_set_next = taken;
        end
        T_JUMP:
        begin
          pc_next     = ir.r.size ? ext_val : alu_out;
          pc_set_next = 1'b1;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      delay    <= '0;
      e_wen_o  <= 1'b0;
      pc_o     <= 32'h0;
      pc_set_o <= 1'b0;
      ccr_o    <= '0;
      halt_o   <= 1'b0;
    end
    else
    begin
      delay    <= delay_next;
      e_wen_o  <= wen_next;
      pc_o     <= pc_next;
      pc_set_o <= pc_set_next;
      ccr_o    <= ccr_next;
      halt_o   <= halt_next;  // sticky until reset
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (wen_next)
    begin
      e_result_o <= result_next;
      e_dest_o   <= ir.r.ra;
    end
  end

  alu alu_i (
    .in1_i  (alu_in1),
    .in2_i  (alu_in2),
    .func_i (alu_func),
    .out_o  (alu_out),
    .c_o    (alu_c),
    .n_o    (alu_n),
    .v_o    (alu_v),
    .z_o    (alu_z)
  );

  a_delay_range: assert property (@(posedge clk_i) disable iff (rst_i)
    delay <= MUL_LATENCY);

  a_no_write_halted: assert property (@(posedge clk_i) disable iff (rst_i)
    halt_o |-> !e_wen_o);

endmodule

/* decode.sv */
module decode (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic [isa_pkg::IR_W-1:0] ir_i,
  input  logic [31:0]              pc_i,
  input  logic                     ir_valid_i,
  input  logic                     stall_i,
  input  logic                     flush_i,
  input  logic                     ex_wen_i,
  input  logic [3:0]               ex_dest_i,
  input  logic [31:0]              ex_result_i,
  input  logic                     wb_en_i,
  input  logic [3:0]               wb_reg_i,
  input  logic [31:0]              wb_data_i,
  output logic [3:0]               ra_addr_o,
  output logic [3:0]               rb_addr_o,
  input  logic [31:0]              ra_data_i,
  input  logic [31:0]              rb_data_i,
  output logic [isa_pkg::IR_W-1:0] d_ir_o,
  output logic [31:0]              d_pc_o,
  output logic                     d_valid_o,
  output logic [31:0]              d_rdata1_o,
  output logic [31:0]              d_rdata2_o
);
  import isa_pkg::*;

  instr_word_t ir;
  logic        valid_q;

  // newest producer wins
  function automatic logic [31:0] fwd(input logic [3:0] src, input logic [31:0] rf_data);
    if (ex_wen_i && ex_dest_i == src)
      return ex_result_i;
    else if (wb_en_i && wb_reg_i == src)
      return wb_data_i;
    else
      return rf_data;
  endfunction

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      valid_q <= 1'b0;
    else if (flush_i)
      valid_q <= 1'b0;  // bubble in place of accepted instr
    else if (!stall_i)
      valid_q <= ir_valid_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (!stall_i)
    begin
      d_ir_o <= ir_i;
      d_pc_o <= pc_i;
    end
  end

  assign ir        = d_ir_o[31:0];
  assign ra_addr_o = ir.r.rb;  // also the MOV source
  assign rb_addr_o = ir.r.rc;
  assign d_valid_o = valid_q & ~flush_i;  // instr behind a taken branch

  always_comb
  begin
    d_rdata1_o = fwd(ra_addr_o, ra_data_i);
    d_rdata2_o = fwd(rb_addr_o, rb_data_i);
  end

  a_hold_on_stall: assert property (@(posedge clk_i) disable iff (rst_i)
    stall_i |=> $stable(d_ir_o));

endmodule

/* alu.sv */
module alu (
  input  logic               [31:0] in1_i,
  input  logic               [31:0] in2_i,
  input  alu_pkg::alu_func_t        func_i,
  output logic               [31:0] out_o,
  output logic                      c_o,
  output logic                      n_o,
  output logic                      v_o,
  output logic                      z_o
);
  import alu_pkg::*;

  always_comb
  begin
    c_o = 1'b0;
    v_o = 1'b0;
    case (func_i)
      ALU_ADD:
      begin
        {c_o, out_o} = {1'b0, in1_i} + {1'b0, in2_i};
        v_o = (in1_i[31] == in2_i[31]) && (out_o[31] != in1_i[31]);
      end
      ALU_SUB:
      begin
        {c_o, out_o} = {1'b0, in1_i} - {1'b0, in2_i};  // c is borrow
        v_o = (in1_i[31] != in2_i[31]) && (out_o[31] != in1_i[31]);
      end
      ALU_AND: out_o = in1_i & in2_i;
      ALU_OR:  out_o = in1_i | in2_i;
      ALU_XOR: out_o = in1_i ^ in2_i;
      ALU_LSL: out_o = in1_i << in2_i[4:0];
      ALU_LSR: out_o = in1_i >> in2_i[4:0];
      ALU_ASR: out_o = $unsigned($signed(in1_i) >>> in2_i[4:0]);
      default: out_o = 32'h0;
    endcase
    n_o = out_o[31];
    z_o = (out_o == 32'h0);
  end

endmodule

/* reg_file.sv */
module reg_file (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic [3:0]  ra_addr_i,
  input  logic [3:0]  rb_addr_i,
  output logic [31:0] ra_data_o,
  output logic [31:0] rb_data_o,
  input  logic        w_en_i,
  input  logic [3:0]  w_addr_i,
  input  logic [31:0] w_data_i
);

  logic [31:0] regs [16];

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      for (int i = 0; i < 16; i++)
        regs[i] <= 32'h0;
    end
    else if (w_en_i)
      regs[w_addr_i] <= w_data_i;
  end

  // no write bypass, decode forwards from result
  assign ra_data_o = regs[ra_addr_i];
  assign rb_data_o = regs[rb_addr_i];

endmodule

/* alu_pkg.sv */
package alu_pkg;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_LSL,
    ALU_LSR,
    ALU_ASR
  } alu_func_t;

  // condition code register layout
  localparam int CCR_W   = 3;
  localparam int CCR_EQ  = 0;
  localparam int CCR_LT  = 1;  // signed less than
  localparam int CCR_LTU = 2;  // unsigned less than

endpackage

/* isa_pkg.sv */
package isa_pkg;

  localparam int IR_W = 64;  // low word plus extended value

  localparam logic [3:0] T_INH    = 4'h0;
  localparam logic [3:0] T_ALU    = 4'h1;
  localparam logic [3:0] T_INT    = 4'h2;
  localparam logic [3:0] T_CMP    = 4'h3;
  localparam logic [3:0] T_MOV    = 4'h4;
  localparam logic [3:0] T_LDI    = 4'h5;
  localparam logic [3:0] T_BRANCH = 4'h6;
  localparam logic [3:0] T_JUMP   = 4'h7;

  localparam logic [3:0] OP_NOP  = 4'h0;
  localparam logic [3:0] OP_HALT = 4'h4;
  localparam logic [3:0] OP_MUL  = 4'h0;  // T_INT only

  localparam logic [3:0] BR_BRA  = 4'h0;
  localparam logic [3:0] BR_BEQ  = 4'h1;
  localparam logic [3:0] BR_BNE  = 4'h2;
  localparam logic [3:0] BR_BGTU = 4'h3;
  localparam logic [3:0] BR_BGT  = 4'h4;
  localparam logic [3:0] BR_BGE  = 4'h5;
  localparam logic [3:0] BR_BLE  = 4'h6;
  localparam logic [3:0] BR_BLT  = 4'h7;
  localparam logic [3:0] BR_BGEU = 4'h8;
  localparam logic [3:0] BR_BLTU = 4'h9;
  localparam logic [3:0] BR_BLEU = 4'ha;

  typedef struct packed {
    logic [3:0]  itype;
    logic [3:0]  op;
    logic [3:0]  ra;      // destination
    logic [3:0]  rb;
    logic [3:0]  rc;
    logic [10:0] unused;
    logic        size;
  } instr_reg_t;

  typedef struct packed {
    logic [3:0]  itype;
    logic [3:0]  op;
    logic [3:0]  ra;
    logic [3:0]  rb;
    logic [14:0] sval;    // signed, word scaled for branches
    logic        size;
  } instr_imm_t;

  typedef union packed {
    instr_reg_t r;
    instr_imm_t i;
  } instr_word_t;

endpackage
